// File: Makefile
# Verilator build and run of the MIPS core testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/mips_alu.sv
// mips_alu
// integer ALU for the core: add, subtract, logic, signed compare,
// shift by shamt and lui

`timescale 1ns/1ps

module mips_alu (
   input  mips_pkg::word_t              rs_data,
   input  mips_pkg::word_t              rt_data,
   input  mips_pkg::word_t              imm_ext,
   input  logic [mips_pkg::shamt_w-1:0] shamt,
   input  mips_pkg::alu_op_e            alu_op,
   input  logic                         alu_use_imm,
   output mips_pkg::word_t              alu_result
);

   mips_pkg::word_t op_b;

   // second operand, immediate for I-type and memory ops
   assign op_b = alu_use_imm ? imm_ext : rt_data;

   always_comb
   begin
      case (alu_op)
         // also forms the lw/sw address
         mips_pkg::alu_add:
            alu_result = rs_data + op_b;
         mips_pkg::alu_sub:
            alu_result = rs_data - op_b;
         mips_pkg::alu_and:
            alu_result = rs_data & op_b;
         mips_pkg::alu_or:
            alu_result = rs_data | op_b;
         mips_pkg::alu_xor:
            alu_result = rs_data ^ op_b;
         mips_pkg::alu_nor:
            alu_result = ~(rs_data | op_b);
         // signed compare for slt and slti
         mips_pkg::alu_slt:
            alu_result = ($signed(rs_data) < $signed(op_b)) ? 32'd1 : 32'd0;
         // shifts always act on rt
         mips_pkg::alu_sll:
            alu_result = rt_data << shamt;
         mips_pkg::alu_srl:
            alu_result = rt_data >> shamt;
         mips_pkg::alu_sra:
            alu_result = $unsigned($signed(rt_data) >>> shamt);
         // immediate into the upper half, low half cleared
         mips_pkg::alu_lui:
            alu_result = {imm_ext[15:0], 16'h0000};
         default:
            alu_result = '0;
      endcase
   end

endmodule

// File: hdl/mips_core.sv
// mips_core
// single-cycle MIPS integer core with one branch delay slot,
// combinational instruction and data memory ports

`timescale 1ns/1ps

module mips_core #(
   parameter mips_pkg::word_t text_start = 32'h00400000
) (
   input  logic                 clk,
   input  logic                 rst_b,
   output mips_pkg::word_addr_t inst_addr,
   input  mips_pkg::word_t      inst,
   output mips_pkg::word_addr_t mem_addr,
   output mips_pkg::word_t      mem_data_in,
   output logic                 mem_we,
   input  mips_pkg::word_t      mem_data_out,
   output logic                 halted
);

   // decoded fields and controls
   mips_pkg::reg_addr_t          rs;
   mips_pkg::reg_addr_t          rt;
   mips_pkg::reg_addr_t          rd;
   mips_pkg::word_t              imm_ext;
   logic [mips_pkg::shamt_w-1:0] shamt;
   logic [25:0]                  jump_target;
   mips_pkg::alu_op_e            alu_op;
   logic                         alu_use_imm;
   mips_pkg::pc_sel_e            pc_sel;
   logic                         branch_ne;
   mips_pkg::wb_sel_e            wb_sel;
   logic                         wb_use_rt;
   logic                         wb_link;
   logic                         reg_we;
   logic                         advance;

   // datapath
   mips_pkg::word_t              rs_data;
   mips_pkg::word_t              rt_data;
   mips_pkg::word_t              alu_result;
   mips_pkg::word_t              link_addr;
   mips_pkg::reg_addr_t          wr_reg;
   mips_pkg::word_t              wr_data;

   mips_decode i_mips_decode (
      .clk         (clk),
      .rst_b       (rst_b),
      .inst        (inst),
      .rs          (rs),
      .rt          (rt),
      .rd          (rd),
      .imm_ext     (imm_ext),
      .shamt       (shamt),
      .jump_target (jump_target),
      .alu_op      (alu_op),
      .alu_use_imm (alu_use_imm),
      .pc_sel      (pc_sel),
      .branch_ne   (branch_ne),
      .wb_sel      (wb_sel),
      .wb_use_rt   (wb_use_rt),
      .wb_link     (wb_link),
      .reg_we      (reg_we),
      .mem_we      (mem_we),
      .advance     (advance),
      .halted      (halted)
   );

   mips_regfile i_mips_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs      (rs),
      .rt      (rt),
      .wr_reg  (wr_reg),
      .wr_data (wr_data),
      .reg_we  (reg_we),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   mips_alu i_mips_alu (
      .rs_data     (rs_data),
      .rt_data     (rt_data),
      .imm_ext     (imm_ext),
      .shamt       (shamt),
      .alu_op      (alu_op),
      .alu_use_imm (alu_use_imm),
      .alu_result  (alu_result)
   );

   mips_pc_unit #(
      .text_start (text_start)
   ) i_mips_pc_unit (
      .clk         (clk),
      .rst_b       (rst_b),
      .advance     (advance),
      .pc_sel      (pc_sel),
      .branch_ne   (branch_ne),
      .rs_data     (rs_data),
      .rt_data     (rt_data),
      .imm_ext     (imm_ext),
      .jump_target (jump_target),
      .inst_addr   (inst_addr),
      .link_addr   (link_addr)
   );

   mips_writeback i_mips_writeback (
      .wb_sel     (wb_sel),
      .wb_use_rt  (wb_use_rt),
      .wb_link    (wb_link),
      .rt         (rt),
      .rd         (rd),
      .alu_result (alu_result),
      .load_data  (mem_data_out),
      .link_addr  (link_addr),
      .wr_reg     (wr_reg),
      .wr_data    (wr_data)
   );

   // word-aligned data port, sw stores rt
   assign mem_addr    = alu_result[31:2];
   assign mem_data_in = rt_data;

endmodule

// File: hdl/mips_decode.sv
// mips_decode
// splits instruction fields, extends the immediate, produces the ALU, PC and
// writeback controls and holds the halt flag raised by syscall

`timescale 1ns/1ps

module mips_decode (
   input  logic                          clk,
   input  logic                          rst_b,
   input  mips_pkg::word_t               inst,
   output mips_pkg::reg_addr_t           rs,
   output mips_pkg::reg_addr_t           rt,
   output mips_pkg::reg_addr_t           rd,
   output mips_pkg::word_t               imm_ext,
   output logic [mips_pkg::shamt_w-1:0]  shamt,
   output logic [25:0]                   jump_target,
   output mips_pkg::alu_op_e             alu_op,
   output logic                          alu_use_imm,
   output mips_pkg::pc_sel_e             pc_sel,
   output logic                          branch_ne,
   output mips_pkg::wb_sel_e             wb_sel,
   output logic                          wb_use_rt,
   output logic                          wb_link,
   output logic                          reg_we,
   output logic                          mem_we,
   output logic                          advance,
   output logic                          halted
);

   logic [mips_pkg::opcode_w-1:0] opcode;
   logic [mips_pkg::opcode_w-1:0] funct;
   logic                          zero_ext;
   logic                          reg_we_dec;
   logic                          mem_we_dec;
   logic                          is_syscall;

   // raw fields
   assign opcode      = inst[31:26];
   assign rs          = inst[25:21];
   assign rt          = inst[20:16];
   assign rd          = inst[15:11];
   assign shamt       = inst[10:6];
   assign funct       = inst[5:0];
   assign jump_target = inst[25:0];

   // logical immediates are zero extended, everything else sign extended
   assign imm_ext = zero_ext ? {16'h0000, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};

   always_comb
   begin
      // defaults describe a no-op, so unknown encodings fall through safely
      alu_op      = mips_pkg::alu_add;
      alu_use_imm = 1'b0;
      zero_ext    = 1'b0;
      pc_sel      = mips_pkg::pc_seq;
      branch_ne   = 1'b0;
      wb_sel      = mips_pkg::wb_alu;
      wb_use_rt   = 1'b0;
      wb_link     = 1'b0;
      reg_we_dec  = 1'b0;
      mem_we_dec  = 1'b0;
      is_syscall  = 1'b0;
      case (opcode)
         mips_pkg::op_special:
         begin
            // R-type writes rd
            reg_we_dec = 1'b1;
            case (funct)
               mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
               mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
               mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
               mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
               mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
               mips_pkg::fn_nor:  alu_op = mips_pkg::alu_nor;
               mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
               mips_pkg::fn_sll:  alu_op = mips_pkg::alu_sll;
               mips_pkg::fn_srl:  alu_op = mips_pkg::alu_srl;
               mips_pkg::fn_sra:  alu_op = mips_pkg::alu_sra;
               mips_pkg::fn_jr:
               begin
                  reg_we_dec = 1'b0;
                  pc_sel     = mips_pkg::pc_reg;
               end
               mips_pkg::fn_syscall:
               begin
                  reg_we_dec = 1'b0;
                  is_syscall = 1'b1;
               end
               default: reg_we_dec = 1'b0;
            endcase
         end
         mips_pkg::op_j:
            pc_sel = mips_pkg::pc_jump;
         mips_pkg::op_jal:
         begin
            // return address goes to $ra
            pc_sel     = mips_pkg::pc_jump;
            wb_sel     = mips_pkg::wb_link;
            wb_link    = 1'b1;
            reg_we_dec = 1'b1;
         end
         mips_pkg::op_beq:
            pc_sel = mips_pkg::pc_branch;
         mips_pkg::op_bne:
         begin
            pc_sel    = mips_pkg::pc_branch;
            branch_ne = 1'b1;
         end
         mips_pkg::op_addiu,
         mips_pkg::op_slti,
         mips_pkg::op_andi,
         mips_pkg::op_ori,
         mips_pkg::op_xori,
         mips_pkg::op_lui:
         begin
            alu_use_imm = 1'b1;
            wb_use_rt   = 1'b1;
            reg_we_dec  = 1'b1;
            case (opcode)
               mips_pkg::op_slti: alu_op = mips_pkg::alu_slt;
               mips_pkg::op_andi: alu_op = mips_pkg::alu_and;
               mips_pkg::op_ori:  alu_op = mips_pkg::alu_or;
               mips_pkg::op_xori: alu_op = mips_pkg::alu_xor;
               mips_pkg::op_lui:  alu_op = mips_pkg::alu_lui;
               default:           alu_op = mips_pkg::alu_add;
            endcase
            zero_ext = (opcode == mips_pkg::op_andi) || (opcode == mips_pkg::op_ori)
                       || (opcode == mips_pkg::op_xori);
         end
         mips_pkg::op_lw:
         begin
            // address is rs + offset, data into rt
            alu_use_imm = 1'b1;
            wb_sel      = mips_pkg::wb_load;
            wb_use_rt   = 1'b1;
            reg_we_dec  = 1'b1;
         end
         mips_pkg::op_sw:
         begin
            alu_use_imm = 1'b1;
            mem_we_dec  = 1'b1;
         end
         default:
         begin
         end
      endcase
   end

   // halt is sticky until reset
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
         halted <= 1'b0;
      else if (is_syscall)
         halted <= 1'b1;
   end

   // nothing commits once halted or while in reset
   assign advance = rst_b & ~halted;
   assign reg_we  = reg_we_dec & advance;
   assign mem_we  = mem_we_dec & advance;

endmodule

// File: hdl/mips_pc_unit.sv
// mips_pc_unit
// current and next PC registers with one delay slot, branch compare,
// branch, jump and register targets, and the jal link address

`timescale 1ns/1ps

module mips_pc_unit #(
   parameter mips_pkg::word_t text_start = 32'h00400000
) (
   input  logic                 clk,
   input  logic                 rst_b,
   input  logic                 advance,
   input  mips_pkg::pc_sel_e    pc_sel,
   input  logic                 branch_ne,
   input  mips_pkg::word_t      rs_data,
   input  mips_pkg::word_t      rt_data,
   input  mips_pkg::word_t      imm_ext,
   input  logic [25:0]          jump_target,
   output mips_pkg::word_addr_t inst_addr,
   output mips_pkg::word_t      link_addr
);

   mips_pkg::word_t pc;
   mips_pkg::word_t next_pc;
   mips_pkg::word_t next_next_pc;
   mips_pkg::word_t branch_addr;
   mips_pkg::word_t jump_addr;
   logic            taken;

   // beq takes on equal, bne on not equal
   assign taken = (rs_data == rt_data) ^ branch_ne;

   // offset is in words, relative to the delay slot
   assign branch_addr = pc + 32'd4 + {imm_ext[29:0], 2'b00};
   // region bits come from the delay slot address
   assign jump_addr   = {next_pc[31:28], jump_target, 2'b00};

   always_comb
   begin
      case (pc_sel)
         mips_pkg::pc_branch:
            next_next_pc = taken ? branch_addr : next_pc + 32'd4;
         mips_pkg::pc_jump:
            next_next_pc = jump_addr;
         mips_pkg::pc_reg:
            next_next_pc = rs_data;
         default:
            next_next_pc = next_pc + 32'd4;
      endcase
   end

   // the redirect lands in next_pc, so the slot after a branch always runs
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc      <= text_start;
         next_pc <= text_start + 32'd4;
      end
      else if (advance)
      begin
         pc      <= next_pc;
         next_pc <= next_next_pc;
      end
   end

   assign inst_addr = pc[31:2];
   // return skips the delay slot
   assign link_addr = pc + 32'd8;

endmodule

// File: hdl/mips_pkg.sv
// mips_pkg
// shared types, instruction encodings and control enums for the
// single-cycle MIPS integer core

package mips_pkg;

   // field widths
   parameter int opcode_w = 6;
   parameter int shamt_w  = 5;

   // byte address or data word
   typedef logic [31:0] word_t;
   // word address as seen on the memory ports
   typedef logic [29:0] word_addr_t;
   // register number
   typedef logic [4:0]  reg_addr_t;

   // primary opcodes, inst[31:26]
   localparam logic [opcode_w-1:0] op_special = 6'h00;
   localparam logic [opcode_w-1:0] op_j       = 6'h02;
   localparam logic [opcode_w-1:0] op_jal     = 6'h03;
   localparam logic [opcode_w-1:0] op_beq     = 6'h04;
   localparam logic [opcode_w-1:0] op_bne     = 6'h05;
   localparam logic [opcode_w-1:0] op_addiu   = 6'h09;
   localparam logic [opcode_w-1:0] op_slti    = 6'h0a;
   localparam logic [opcode_w-1:0] op_andi    = 6'h0c;
   localparam logic [opcode_w-1:0] op_ori     = 6'h0d;
   localparam logic [opcode_w-1:0] op_xori    = 6'h0e;
   localparam logic [opcode_w-1:0] op_lui     = 6'h0f;
   localparam logic [opcode_w-1:0] op_lw      = 6'h23;
   localparam logic [opcode_w-1:0] op_sw      = 6'h2b;

   // function codes for op_special, inst[5:0]
   localparam logic [opcode_w-1:0] fn_sll     = 6'h00;
   localparam logic [opcode_w-1:0] fn_srl     = 6'h02;
   localparam logic [opcode_w-1:0] fn_sra     = 6'h03;
   localparam logic [opcode_w-1:0] fn_jr      = 6'h08;
   localparam logic [opcode_w-1:0] fn_syscall = 6'h0c;
   localparam logic [opcode_w-1:0] fn_addu    = 6'h21;
   localparam logic [opcode_w-1:0] fn_subu    = 6'h23;
   localparam logic [opcode_w-1:0] fn_and     = 6'h24;
   localparam logic [opcode_w-1:0] fn_or      = 6'h25;
   localparam logic [opcode_w-1:0] fn_xor     = 6'h26;
   localparam logic [opcode_w-1:0] fn_nor     = 6'h27;
   localparam logic [opcode_w-1:0] fn_slt     = 6'h2a;

   // ALU operation select
   typedef enum logic [3:0] {
      alu_add = 4'd0,
      alu_sub = 4'd1,
      alu_and = 4'd2,
      alu_or  = 4'd3,
      alu_xor = 4'd4,
      alu_nor = 4'd5,
      alu_slt = 4'd6,
      alu_sll = 4'd7,
      alu_srl = 4'd8,
      alu_sra = 4'd9,
      alu_lui = 4'd10
   } alu_op_e;

   // source of the next-next PC
   typedef enum logic [1:0] {
      pc_seq    = 2'd0,
      pc_branch = 2'd1,
      pc_jump   = 2'd2,
      pc_reg    = 2'd3
   } pc_sel_e;

   // source of the register write data
   typedef enum logic [1:0] {
      wb_alu  = 2'd0,
      wb_load = 2'd1,
      wb_link = 2'd2
   } wb_sel_e;

   // $ra, destination of jal
   localparam reg_addr_t link_reg = 5'd31;

endpackage

// File: hdl/mips_regfile.sv
// mips_regfile
// 32 x 32-bit register file, two combinational reads and one clocked write,
// register zero hardwired to zero

`timescale 1ns/1ps

module mips_regfile (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::reg_addr_t rs,
   input  mips_pkg::reg_addr_t rt,
   input  mips_pkg::reg_addr_t wr_reg,
   input  mips_pkg::word_t     wr_data,
   input  logic                reg_we,
   output mips_pkg::word_t     rs_data,
   output mips_pkg::word_t     rt_data
);

   mips_pkg::word_t regs [32];

   // whole file clears on reset, $zero never takes a write
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end
      else if (reg_we && (wr_reg != 5'd0))
      begin
         regs[wr_reg] <= wr_data;
      end
   end

   // reads see the old value in the writing cycle
   assign rs_data = (rs == 5'd0) ? '0 : regs[rs];
   assign rt_data = (rt == 5'd0) ? '0 : regs[rt];

endmodule

// File: hdl/mips_writeback.sv
// mips_writeback
// picks register write data from ALU, load or link source and the
// destination from rd, rt or $ra

`timescale 1ns/1ps

module mips_writeback (
   input  mips_pkg::wb_sel_e   wb_sel,
   input  logic                wb_use_rt,
   input  logic                wb_link,
   input  mips_pkg::reg_addr_t rt,
   input  mips_pkg::reg_addr_t rd,
   input  mips_pkg::word_t     alu_result,
   input  mips_pkg::word_t     load_data,
   input  mips_pkg::word_t     link_addr,
   output mips_pkg::reg_addr_t wr_reg,
   output mips_pkg::word_t     wr_data
);

   always_comb
   begin
      case (wb_sel)
         mips_pkg::wb_load: wr_data = load_data;
         mips_pkg::wb_link: wr_data = link_addr;
         default:           wr_data = alu_result;
      endcase
   end

   // jal overrides, then I-type and loads use rt, R-type uses rd
   assign wr_reg = wb_link ? mips_pkg::link_reg : (wb_use_rt ? rt : rd);

endmodule

// File: test/tb_mips_core.sv
// tb_mips_core
// testbench for the single-cycle MIPS core, assembles a program, predicts
// every store and checks the stores, reset state and halt behavior

`timescale 1ns/1ps

module tb_mips_core;

   localparam mips_pkg::word_t text_start = 32'h00400000;
   localparam mips_pkg::word_t data_base  = 32'h10010000;
   localparam logic [31:0]     lfsr_taps  = 32'h80200003;

   logic                 clk;
   logic                 rst_b;
   mips_pkg::word_addr_t inst_addr;
   mips_pkg::word_t      inst;
   mips_pkg::word_addr_t mem_addr;
   mips_pkg::word_t      mem_data_in;
   logic                 mem_we;
   mips_pkg::word_t      mem_data_out;
   logic                 halted;

   // expected stores in program order, tagged with their test
   mips_pkg::word_t exp_addr [$];
   mips_pkg::word_t exp_data [$];
   int              exp_test [$];
   int              pending [1:6];
   int              fails [1:6];
   int              cur_test;
   int              pc_idx;
   logic [15:0]     next_off;
   logic [31:0]     lfsr_state;

   mips_core #(
      .text_start (text_start)
   ) i_mips_core (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_we       (mem_we),
      .mem_data_out (mem_data_out),
      .halted       (halted)
   );

   tb_mips_mem i_mem (
      .clk          (clk),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_we       (mem_we),
      .mem_data_out (mem_data_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // instruction encoders
   function automatic mips_pkg::word_t enc_r(logic [5:0] fn, mips_pkg::reg_addr_t rs,
                                             mips_pkg::reg_addr_t rt,
                                             mips_pkg::reg_addr_t rd, logic [4:0] sh);
      return {mips_pkg::op_special, rs, rt, rd, sh, fn};
   endfunction

   function automatic mips_pkg::word_t enc_i(logic [5:0] op, mips_pkg::reg_addr_t rs,
                                             mips_pkg::reg_addr_t rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic mips_pkg::word_t enc_j(logic [5:0] op, logic [25:0] tgt);
      return {op, tgt};
   endfunction

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ lfsr_taps;
      else
         return s >> 1;
   endfunction

   task automatic take_random_word(output mips_pkg::word_t w);
      w = '0;
      for (int i = 0; i < 32; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         w = {w[30:0], lfsr_state[0]};
      end
   endtask

   // the ten register ops in test order
   function automatic logic [5:0] fn_of(int k);
      case (k)
         0: return mips_pkg::fn_addu;
         1: return mips_pkg::fn_subu;
         2: return mips_pkg::fn_and;
         3: return mips_pkg::fn_or;
         4: return mips_pkg::fn_xor;
         5: return mips_pkg::fn_nor;
         6: return mips_pkg::fn_slt;
         7: return mips_pkg::fn_sll;
         8: return mips_pkg::fn_srl;
         default: return mips_pkg::fn_sra;
      endcase
   endfunction

   // expected register-op result, shifts act on b
   function automatic mips_pkg::word_t expect_r(logic [5:0] fn, mips_pkg::word_t a,
                                                mips_pkg::word_t b, logic [4:0] sh);
      case (fn)
         mips_pkg::fn_addu: return a + b;
         mips_pkg::fn_subu: return a - b;
         mips_pkg::fn_and:  return a & b;
         mips_pkg::fn_or:   return a | b;
         mips_pkg::fn_xor:  return a ^ b;
         mips_pkg::fn_nor:  return ~(a | b);
         // differing signs decide alone, equal signs compare as unsigned
         mips_pkg::fn_slt:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
         mips_pkg::fn_sll:  return b << sh;
         mips_pkg::fn_srl:  return b >> sh;
         // vacated top bits take the sign of b
         default:           return (b >> sh) | (~(32'hffffffff >> sh) & {32{b[31]}});
      endcase
   endfunction

   task automatic emit(mips_pkg::word_t w);
      i_mem.imem[pc_idx] = w;
      pc_idx++;
   endtask

   // sw with a predicted address and value
   task automatic store_expect(int t, mips_pkg::reg_addr_t rt, mips_pkg::word_t rt_val,
                               mips_pkg::reg_addr_t base, mips_pkg::word_t base_val,
                               logic [15:0] off);
      emit(enc_i(mips_pkg::op_sw, base, rt, off));
      exp_addr.push_back(base_val + {{16{off[15]}}, off});
      exp_data.push_back(rt_val);
      exp_test.push_back(t);
      pending[t]++;
   endtask

   // store on the next $1 slot
   task automatic store_next(int t, mips_pkg::reg_addr_t rt, mips_pkg::word_t rt_val);
      store_expect(t, rt, rt_val, 5'd1, data_base, next_off);
      next_off = next_off + 16'd4;
   endtask

   // store on a path that must never run
   task automatic emit_skipped_store();
      emit(enc_i(mips_pkg::op_sw, 5'd1, 5'd9, 16'h03f0));
   endtask

   task automatic build_program();
      mips_pkg::word_t a;
      mips_pkg::word_t b;
      mips_pkg::word_t v;
      mips_pkg::word_t tgt;
      logic [5:0]      fn;
      logic [15:0]     off;
      take_random_word(a);
      take_random_word(b);
      i_mem.dmem[0] = a;
      i_mem.dmem[1] = b;
      pc_idx   = 0;
      next_off = 16'h0040;
      // $1 = data base, $2/$3 = random operands
      emit(enc_i(mips_pkg::op_lui, 5'd0, 5'd1, data_base[31:16]));
      emit(enc_i(mips_pkg::op_lw, 5'd1, 5'd2, 16'd0));
      emit(enc_i(mips_pkg::op_lw, 5'd1, 5'd3, 16'd4));
      for (int k = 0; k < 10; k++)
      begin
         fn = fn_of(k);
         if (fn == mips_pkg::fn_sll || fn == mips_pkg::fn_srl || fn == mips_pkg::fn_sra)
            emit(enc_r(fn, 5'd0, 5'd3, 5'd4, 5'd5));
         else
            emit(enc_r(fn, 5'd2, 5'd3, 5'd4, 5'd0));
         store_next(2, 5'd4, expect_r(fn, a, b, 5'd5));
      end
      // immediates, stored below $6 with negative offsets
      emit(enc_i(mips_pkg::op_addiu, 5'd1, 5'd6, 16'h0100));
      off = 16'hfffc;
      for (int k = 0; k < 6; k++)
      begin
         case (k)
            0:
            begin
               emit(enc_i(mips_pkg::op_addiu, 5'd2, 5'd5, 16'h8123));
               v = a + 32'hffff8123;
            end
            1:
            begin
               // 0 < -16 is false only for a signed compare with a sign-extended immediate
               emit(enc_i(mips_pkg::op_slti, 5'd0, 5'd5, 16'hfff0));
               v = 32'd0;
            end
            2:
            begin
               emit(enc_i(mips_pkg::op_andi, 5'd2, 5'd5, 16'h9abc));
               v = a & 32'h00009abc;
            end
            3:
            begin
               emit(enc_i(mips_pkg::op_ori, 5'd2, 5'd5, 16'h9abc));
               v = a | 32'h00009abc;
            end
            4:
            begin
               emit(enc_i(mips_pkg::op_xori, 5'd2, 5'd5, 16'h9abc));
               v = a ^ 32'h00009abc;
            end
            default:
            begin
               emit(enc_i(mips_pkg::op_lui, 5'd0, 5'd5, 16'h8765));
               v = 32'h87650000;
            end
         endcase
         store_expect(3, 5'd5, v, 5'd6, data_base + 32'h100, off);
         off = off - 16'd4;
      end
      // branches, $7 = $8 = 5 and $9 = 6
      emit(enc_i(mips_pkg::op_addiu, 5'd0, 5'd7, 16'd5));
      emit(enc_i(mips_pkg::op_addiu, 5'd0, 5'd8, 16'd5));
      emit(enc_i(mips_pkg::op_addiu, 5'd0, 5'd9, 16'd6));
      emit(enc_i(mips_pkg::op_beq, 5'd7, 5'd8, 16'd2));
      store_next(4, 5'd7, 32'd5);
      emit_skipped_store();
      store_next(4, 5'd8, 32'd5);
      emit(enc_i(mips_pkg::op_beq, 5'd7, 5'd9, 16'd2));
      store_next(4, 5'd7, 32'd5);
      store_next(4, 5'd9, 32'd6);
      store_next(4, 5'd8, 32'd5);
      emit(enc_i(mips_pkg::op_bne, 5'd7, 5'd9, 16'd2));
      store_next(4, 5'd9, 32'd6);
      emit_skipped_store();
      store_next(4, 5'd7, 32'd5);
      emit(enc_i(mips_pkg::op_bne, 5'd7, 5'd8, 16'd2));
      store_next(4, 5'd8, 32'd5);
      store_next(4, 5'd9, 32'd6);
      store_next(4, 5'd7, 32'd5);
      // j lands three words on
      tgt = text_start + 32'(4 * (pc_idx + 3));
      emit(enc_j(mips_pkg::op_j, tgt[27:2]));
      store_next(5, 5'd9, 32'd6);
      emit_skipped_store();
      store_next(5, 5'd7, 32'd5);
      // jal, then $ra stored at the target
      v   = text_start + 32'(4 * pc_idx) + 32'd8;
      tgt = text_start + 32'(4 * (pc_idx + 3));
      emit(enc_j(mips_pkg::op_jal, tgt[27:2]));
      store_next(5, 5'd8, 32'd5);
      emit_skipped_store();
      store_next(5, 5'd31, v);
      // jr through $10, jr sits two words after the lui
      tgt = text_start + 32'(4 * (pc_idx + 5));
      emit(enc_i(mips_pkg::op_lui, 5'd0, 5'd10, tgt[31:16]));
      emit(enc_i(mips_pkg::op_ori, 5'd10, 5'd10, tgt[15:0]));
      emit(enc_r(mips_pkg::fn_jr, 5'd10, 5'd0, 5'd0, 5'd0));
      store_next(5, 5'd9, 32'd6);
      emit_skipped_store();
      store_next(5, 5'd10, tgt);
      // halt, the store after it must not run
      emit(enc_r(mips_pkg::fn_syscall, 5'd0, 5'd0, 5'd0, 5'd0));
      emit_skipped_store();
   endtask

   // every store is matched against the head of the queue
   always @(posedge clk)
   begin
      if (rst_b && mem_we)
      begin
         assert (exp_addr.size() != 0)
         else
         begin
            $display("ERROR %0t: store with none expected, addr %h data %h", $time,
                     {mem_addr, 2'b00}, mem_data_in);
            fails[cur_test]++;
         end
         if (exp_addr.size() != 0)
         begin
            assert (mem_addr == exp_addr[0][31:2] && mem_data_in == exp_data[0])
            else
            begin
               $display("ERROR %0t: store got %h <- %h, expected %h <- %h", $time,
                        {mem_addr, 2'b00}, mem_data_in, exp_addr[0], exp_data[0]);
               fails[exp_test[0]]++;
            end
            pending[exp_test[0]]--;
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            void'(exp_test.pop_front());
         end
      end
   end

   task automatic report_test(int t, string name);
      if (fails[t] == 0)
         $display("test %0d %s: ok", t, name);
      else
         $display("test %0d %s: failed with %0d errors", t, name, fails[t]);
   endtask

   task automatic check_reset_state();
      assert (!halted && !mem_we && inst_addr == text_start[31:2])
      else
      begin
         $display("ERROR %0t: reset state wrong, halted %b mem_we %b inst_addr %h",
                  $time, halted, mem_we, inst_addr);
         fails[1]++;
      end
   endtask

   task automatic wait_stores(int t, string name);
      int cnt;
      cnt      = 0;
      cur_test = t;
      while (pending[t] != 0 && cnt < 2000)
      begin
         @(negedge clk);
         cnt++;
      end
      if (pending[t] != 0)
      begin
         $display("test %0d timed out with %0d stores still missing", t, pending[t]);
         fails[t]++;
      end
      report_test(t, name);
   endtask

   initial
   begin
      mips_pkg::word_addr_t held_addr;
      int                   cnt;
      int                   failed;
      rst_b      = 1'b0;
      lfsr_state = 32'h9e7e532e;
      cur_test   = 1;
      for (int t = 1; t <= 6; t++)
      begin
         pending[t] = 0;
         fails[t]   = 0;
      end
      // let the memory fill settle before loading
      #1;
      build_program();
      repeat (4)
      begin
         @(posedge clk);
         @(negedge clk);
         check_reset_state();
      end
      @(posedge clk);
      rst_b <= 1'b1;
      @(negedge clk);
      check_reset_state();
      report_test(1, "reset");
      wait_stores(2, "register ALU ops");
      wait_stores(3, "immediate ops");
      wait_stores(4, "branches");
      wait_stores(5, "jumps");
      cur_test = 6;
      cnt      = 0;
      while (!halted && cnt < 200)
      begin
         @(negedge clk);
         cnt++;
      end
      if (!halted)
      begin
         $display("test 6 halted never rose after syscall");
         fails[6]++;
      end
      held_addr = inst_addr;
      repeat (20)
      begin
         @(negedge clk);
         assert (inst_addr == held_addr && !mem_we)
         else
         begin
            $display("ERROR %0t: core moved after halt, inst_addr %h mem_we %b", $time,
                     inst_addr, mem_we);
            fails[6]++;
         end
      end
      assert (exp_addr.size() == 0)
      else
      begin
         $display("ERROR %0t: %0d expected stores never arrived", $time, exp_addr.size());
         fails[6]++;
      end
      report_test(6, "halt");
      failed = 0;
      for (int t = 1; t <= 6; t++)
      begin
         if (fails[t] != 0)
            failed++;
      end
      $display("tests run: 6, passed: %0d, failed: %0d", 6 - failed, failed);
      if (failed == 0)
      begin
         $display("TEST RESULT: PASS");
      end
      else
      begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: test/tb_mips_mem.sv
// tb_mips_mem
// instruction and data memory model for the core testbench, combinational
// reads and a clocked word write

`timescale 1ns/1ps

module tb_mips_mem (
   input  logic                 clk,
   input  mips_pkg::word_addr_t inst_addr,
   output mips_pkg::word_t      inst,
   input  mips_pkg::word_addr_t mem_addr,
   input  mips_pkg::word_t      mem_data_in,
   input  logic                 mem_we,
   output mips_pkg::word_t      mem_data_out
);

   // 1k words each, indexed by the low word-address bits
   mips_pkg::word_t imem [1024];
   mips_pkg::word_t dmem [1024];

   initial
   begin
      for (int i = 0; i < 1024; i++)
      begin
         // all-zero word is sll $0, a no-op
         imem[i] = '0;
         // fill tagged with the full index
         dmem[i] = 32'hc0de0000 | i;
      end
   end

   assign inst         = imem[inst_addr[9:0]];
   assign mem_data_out = dmem[mem_addr[9:0]];

   always @(posedge clk)
   begin
      if (mem_we)
         dmem[mem_addr[9:0]] <= mem_data_in;
   end

endmodule

// File: verilog.f
hdl/mips_pkg.sv
hdl/mips_decode.sv
hdl/mips_regfile.sv
hdl/mips_alu.sv
hdl/mips_pc_unit.sv
hdl/mips_writeback.sv
hdl/mips_core.sv
test/tb_mips_mem.sv
test/tb_mips_core.sv
